// ==== rfPkg.sv ====
// shared widths and default sizes for the register file design and its testbench; import where needed
`default_nettype none

package rfPkg;

	// default sizes, used by the top level as parameter defaults
	localparam int DefaultDataWidth = 32;
	localparam int DefaultRegCount = 32;

	// index width follows the register count
	localparam int DefaultIdxWidth = $clog2(DefaultRegCount);

	// register index, 5 bits for 32 registers
	typedef logic [DefaultIdxWidth-1:0] regIdxT;

	// one data word as stored in the array
	typedef logic [DefaultDataWidth-1:0] wordT;

	// register 0 is hardwired to zero
	localparam regIdxT ZeroReg = '0;

	// handy data patterns for sweeps
	localparam wordT WordZeros = '0;
	localparam wordT WordOnes = '1;

endpackage

`default_nettype wire

// ==== writeArbiter.sv ====
// merges execute and load writeback strobes onto the single register file write port
`default_nettype none
`timescale 1ns/100ps

module writeArbiter #(
	parameter int DataWidth = rfPkg::DefaultDataWidth,
	parameter int RegCount = rfPkg::DefaultRegCount,
	localparam int IdxWidth = $clog2(RegCount)
) (
	input wire CLK,
	input wire rst,

	// execute stage writeback
	input wire exStrobe,
	input wire [IdxWidth-1:0] exSel,
	input wire [DataWidth-1:0] exData,

	// load unit writeback
	input wire ldStrobe,
	input wire [IdxWidth-1:0] ldSel,
	input wire [DataWidth-1:0] ldData,

	// registered write port
	output logic wen,
	output logic [IdxWidth-1:0] wsel,
	output logic [DataWidth-1:0] wdat
);

	// one deferred slot per source
	logic exPend;
	logic [IdxWidth-1:0] exPendSel;
	logic [DataWidth-1:0] exPendData;
	logic ldPend;
	logic [IdxWidth-1:0] ldPendSel;
	logic [DataWidth-1:0] ldPendData;

	// which request commits this cycle
	logic takeExSlot;
	logic takeLdSlot;
	logic takeExIn;
	logic takeLdIn;

	// strobes that lose and go into a slot
	logic deferEx;
	logic deferLd;

	// next values for the write port
	logic nextWen;
	logic [IdxWidth-1:0] nextSel;
	logic [DataWidth-1:0] nextData;

	// pick order: held slots, then execute, then load
	always_comb begin
		takeExSlot = exPend;
		takeLdSlot = !exPend && ldPend;
		takeExIn = !exPend && !ldPend && exStrobe;
		takeLdIn = !exPend && !ldPend && !exStrobe && ldStrobe;
	end

	// a strobe not served now waits one cycle in its slot
	assign deferEx = exStrobe && !takeExIn;
	assign deferLd = ldStrobe && !takeLdIn;

	assign nextWen = takeExSlot || takeLdSlot || takeExIn || takeLdIn;

	// write port mux
	always_comb begin
		nextSel = exSel;
		nextData = exData;
		if (takeExSlot) begin
			nextSel = exPendSel;
			nextData = exPendData;
		end else if (takeLdSlot) begin
			nextSel = ldPendSel;
			nextData = ldPendData;
		end else if (takeLdIn) begin
			nextSel = ldSel;
			nextData = ldData;
		end
	end

	// control state: write strobe and slot flags
	always_ff @(posedge CLK) begin
		if (rst) begin
			wen <= 1'b0;
			exPend <= 1'b0;
			ldPend <= 1'b0;
		end else begin
			wen <= nextWen;
			// a served slot empties, a loser fills it again
			exPend <= (exPend && !takeExSlot) || deferEx;
			ldPend <= (ldPend && !takeLdSlot) || deferLd;
		end
	end

	// payload, only meaningful when the matching flag is set
	always_ff @(posedge CLK) begin
		wsel <= nextSel;
		wdat <= nextData;
		if (deferEx) begin
			exPendSel <= exSel;
			exPendData <= exData;
		end
		if (deferLd) begin
			ldPendSel <= ldSel;
			ldPendData <= ldData;
		end
	end

	// sources strobe at most every other cycle
	exStrobeSpacing: assert property (
		@(posedge CLK) disable iff (rst)
		exStrobe |=> !exStrobe
	) else $error("execute strobed in two consecutive cycles");

	ldStrobeSpacing: assert property (
		@(posedge CLK) disable iff (rst)
		ldStrobe |=> !ldStrobe
	) else $error("load strobed in two consecutive cycles");

	// a slot that is still full must not take a new request
	slotNoOverrun: assert property (
		@(posedge CLK) disable iff (rst)
		!(exPend && deferEx) && !(ldPend && deferLd)
	) else $error("deferred slot refilled while still full");

	// single write port, so one commit per cycle at most
	oneCommit: assert property (
		@(posedge CLK) disable iff (rst)
		$onehot0({takeExSlot, takeLdSlot, takeExIn, takeLdIn})
	) else $error("more than one writeback committed in a cycle");

	// a deferred load reaches the write port two cycles after its strobe
	deferredLands: assert property (
		@(posedge CLK) disable iff (rst)
		deferLd |=> ##1 (wen && wsel == $past(ldSel, 2))
	) else $error("deferred load did not commit in time");

endmodule

`default_nettype wire

// ==== regFile.sv ====
// MIPS style register array with two combinational read ports, one write port and a zero register
`default_nettype none
`timescale 1ns/100ps

module regFile #(
	parameter int DataWidth = rfPkg::DefaultDataWidth,
	parameter int RegCount = rfPkg::DefaultRegCount,
	localparam int IdxWidth = $clog2(RegCount)
) (
	input wire CLK,
	input wire rst,

	// write port, driven by the arbiter
	input wire wen,
	input wire [IdxWidth-1:0] wsel,
	input wire [DataWidth-1:0] wdat,

	// read ports
	input wire [IdxWidth-1:0] rsel1,
	input wire [IdxWidth-1:0] rsel2,
	output logic [DataWidth-1:0] rdat1,
	output logic [DataWidth-1:0] rdat2
);

	// the array itself
	logic [DataWidth-1:0] regs [RegCount];

	// write is accepted only for a real, nonzero register
	logic writeOk;

	// true if the index points at a register that exists
	function automatic logic inRange(input logic [IdxWidth-1:0] sel);
		return int'(sel) < RegCount;
	endfunction

	// one read port, shared by both outputs
	// zero register first, then the bypass, then the array
	function automatic logic [DataWidth-1:0] readPort(input logic [IdxWidth-1:0] sel);
		logic [DataWidth-1:0] value;
		if (sel == '0 || !inRange(sel)) begin
			value = '0;
		end else if (writeOk && wsel == sel) begin
			value = wdat;
		end else begin
			value = regs[sel];
		end
		return value;
	endfunction

	assign writeOk = wen && wsel != '0 && inRange(wsel);

	// array update, all entries clear on reset
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeOk) begin
			regs[wsel] <= wdat;
		end
	end

	// combinational reads with write-to-read forwarding
	always_comb begin
		rdat1 = readPort(rsel1);
		rdat2 = readPort(rsel2);
	end

	// the array entry itself stays clear outside reset
	zeroRegClear: assert property (
		@(posedge CLK) disable iff (rst)
		regs[0] == '0
	) else $error("register 0 holds a nonzero value");

endmodule

`default_nettype wire

// ==== regFileTop.sv ====
// top level: execute and load writeback sources through the arbiter into the register file
`default_nettype none
`timescale 1ns/100ps

module regFileTop #(
	parameter int DataWidth = rfPkg::DefaultDataWidth,
	parameter int RegCount = rfPkg::DefaultRegCount,
	localparam int IdxWidth = $clog2(RegCount)
) (
	input wire CLK,
	input wire rst,

	// execute port
	input wire exStrobe,
	input wire [IdxWidth-1:0] exSel,
	input wire [DataWidth-1:0] exData,

	// load port
	input wire ldStrobe,
	input wire [IdxWidth-1:0] ldSel,
	input wire [DataWidth-1:0] ldData,

	// read ports
	input wire [IdxWidth-1:0] rsel1,
	input wire [IdxWidth-1:0] rsel2,
	output logic [DataWidth-1:0] rdat1,
	output logic [DataWidth-1:0] rdat2
);

	// write port between arbiter and array
	logic wen;
	logic [IdxWidth-1:0] wsel;
	logic [DataWidth-1:0] wdat;

	writeArbiter #(
		.DataWidth(DataWidth),
		.RegCount(RegCount)
	) arb0 (
		.CLK(CLK),
		.rst(rst),
		.exStrobe(exStrobe),
		.exSel(exSel),
		.exData(exData),
		.ldStrobe(ldStrobe),
		.ldSel(ldSel),
		.ldData(ldData),
		.wen(wen),
		.wsel(wsel),
		.wdat(wdat)
	);

	regFile #(
		.DataWidth(DataWidth),
		.RegCount(RegCount)
	) rf0 (
		.CLK(CLK),
		.rst(rst),
		.wen(wen),
		.wsel(wsel),
		.wdat(wdat),
		.rsel1(rsel1),
		.rsel2(rsel2),
		.rdat1(rdat1),
		.rdat2(rdat2)
	);

endmodule

`default_nettype wire

// ==== regFileTb.sv ====
// testbench for regFileTop; drives both writeback sources, checks reads against a model, run via sim.f
`default_nettype none
`timescale 1ns/100ps

module regFileTb;

	import rfPkg::*;

	localparam int ClkPeriod = 4;
	localparam int unsigned Seed = 32'hdedd216a;

	// test lengths
	localparam int TieCount = 16;
	localparam int Rounds = 24;
	localparam int BurstLen = 8;
	localparam int ReadLen = 4;
	localparam int RoundSteps = 4;

	// a step takes at most 4 cycles, a random round counts as 4 steps
	localparam int TotalSteps = DefaultRegCount + 3 + 2 * (DefaultRegCount - 1)
		+ 2 * TieCount + Rounds * RoundSteps;
	localparam int WatchdogCycles = TotalSteps * 4 + 64;

	logic CLK = 1'b0;
	logic rst;

	// DUT ports
	logic exStrobe;
	regIdxT exSel;
	wordT exData;
	logic ldStrobe;
	regIdxT ldSel;
	wordT ldData;
	regIdxT rsel1;
	regIdxT rsel2;
	wordT rdat1;
	wordT rdat2;

	// model of the write port and the two deferred slots
	logic mWen;
	regIdxT mWsel;
	wordT mWdat;
	logic mExPend;
	regIdxT mExSel;
	wordT mExData;
	logic mLdPend;
	regIdxT mLdSel;
	wordT mLdData;
	wordT mRegs [DefaultRegCount];

	// expected reads once nothing is in flight
	wordT settled1;
	wordT settled2;

	// cycles since the last strobe, saturating
	logic [1:0] idleCycles;

	always #(ClkPeriod / 2) CLK = ~CLK;

	regFileTop dut0 (
		.CLK(CLK),
		.rst(rst),
		.exStrobe(exStrobe),
		.exSel(exSel),
		.exData(exData),
		.ldStrobe(ldStrobe),
		.ldSel(ldSel),
		.ldData(ldData),
		.rsel1(rsel1),
		.rsel2(rsel2),
		.rdat1(rdat1),
		.rdat2(rdat2)
	);

	task automatic abortRun();
		$display("test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic reportMismatch(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		abortRun();
	endtask

	// reference model, one commit per cycle
	always @(posedge CLK) begin : modelStep
		logic exGoes;
		logic ldGoes;
		exGoes = 1'b0;
		ldGoes = 1'b0;
		if (rst) begin
			mWen <= 1'b0;
			mExPend <= 1'b0;
			mLdPend <= 1'b0;
			for (int i = 0; i < DefaultRegCount; i++) begin
				mRegs[i] <= WordZeros;
			end
		end else begin
			// the write on the port lands at this edge
			if (mWen && mWsel != ZeroReg) begin
				mRegs[mWsel] <= mWdat;
			end
			// held slots first, then execute, then load
			if (mExPend) begin
				mWen <= 1'b1;
				mWsel <= mExSel;
				mWdat <= mExData;
			end else if (mLdPend) begin
				mWen <= 1'b1;
				mWsel <= mLdSel;
				mWdat <= mLdData;
			end else if (exStrobe) begin
				exGoes = 1'b1;
				mWen <= 1'b1;
				mWsel <= exSel;
				mWdat <= exData;
			end else if (ldStrobe) begin
				ldGoes = 1'b1;
				mWen <= 1'b1;
				mWsel <= ldSel;
				mWdat <= ldData;
			end else begin
				mWen <= 1'b0;
			end
			// a strobe that did not go through waits in its slot
			if (exStrobe && !exGoes) begin
				mExPend <= 1'b1;
				mExSel <= exSel;
				mExData <= exData;
			end else if (mExPend) begin
				mExPend <= 1'b0;
			end
			// load slot drains only behind an empty execute slot
			if (ldStrobe && !ldGoes) begin
				mLdPend <= 1'b1;
				mLdSel <= ldSel;
				mLdData <= ldData;
			end else if (mLdPend && !mExPend) begin
				mLdPend <= 1'b0;
			end
		end
	end

	always @(posedge CLK) begin
		if (rst || exStrobe || ldStrobe) begin
			idleCycles <= 2'd0;
		end else if (idleCycles != 2'd3) begin
			idleCycles <= idleCycles + 2'd1;
		end
	end

	always_comb begin
		settled1 = (rsel1 == ZeroReg) ? WordZeros : mRegs[rsel1];
		settled2 = (rsel2 == ZeroReg) ? WordZeros : mRegs[rsel2];
	end

	// reads 3 cycles after the last strobe
	settledRead1: assert property (
		@(posedge CLK) disable iff (rst)
		idleCycles >= 2'd2 |-> rdat1 == settled1
	) else reportMismatch($sformatf("port 1 read r%0d as %h, expected %h",
		$sampled(rsel1), $sampled(rdat1), $sampled(settled1)));

	settledRead2: assert property (
		@(posedge CLK) disable iff (rst)
		idleCycles >= 2'd2 |-> rdat2 == settled2
	) else reportMismatch($sformatf("port 2 read r%0d as %h, expected %h",
		$sampled(rsel2), $sampled(rdat2), $sampled(settled2)));

	// register 0 at any time
	zeroRead: assert property (
		@(posedge CLK) disable iff (rst)
		(rsel1 != ZeroReg || rdat1 == WordZeros) && (rsel2 != ZeroReg || rdat2 == WordZeros)
	) else reportMismatch($sformatf("register 0 read as %h / %h",
		$sampled(rdat1), $sampled(rdat2)));

	// arbiter output against the model's commit order
	writePortMatch: assert property (
		@(posedge CLK) disable iff (rst)
		dut0.wen == mWen && (!mWen || (dut0.wsel == mWsel && dut0.wdat == mWdat))
	) else reportMismatch($sformatf("write port wen=%b r%0d=%h, expected wen=%b r%0d=%h",
		$sampled(dut0.wen), $sampled(dut0.wsel), $sampled(dut0.wdat),
		$sampled(mWen), $sampled(mWsel), $sampled(mWdat)));

	// same-cycle write forwarded to the read ports
	bypass1: assert property (
		@(posedge CLK) disable iff (rst)
		dut0.wen && dut0.wsel != ZeroReg && rsel1 == dut0.wsel |-> rdat1 == mWdat
	) else reportMismatch($sformatf("port 1 bypass r%0d gave %h, expected %h",
		$sampled(rsel1), $sampled(rdat1), $sampled(mWdat)));

	bypass2: assert property (
		@(posedge CLK) disable iff (rst)
		dut0.wen && dut0.wsel != ZeroReg && rsel2 == dut0.wsel |-> rdat2 == mWdat
	) else reportMismatch($sformatf("port 2 bypass r%0d gave %h, expected %h",
		$sampled(rsel2), $sampled(rdat2), $sampled(mWdat)));

	// zeros, ones or a random word
	function automatic wordT randomWord();
		int unsigned pick;
		pick = $urandom % 4;
		if (pick == 0) begin
			return WordZeros;
		end else if (pick == 1) begin
			return WordOnes;
		end
		return wordT'($urandom);
	endfunction

	function automatic regIdxT anyReg();
		return regIdxT'($urandom % DefaultRegCount);
	endfunction

	function automatic regIdxT nonzeroReg();
		return regIdxT'(1 + $urandom % (DefaultRegCount - 1));
	endfunction

	// nonzero and different from sel
	function automatic regIdxT otherReg(input regIdxT sel);
		int unsigned offset;
		offset = $urandom % (DefaultRegCount - 2);
		return regIdxT'(1 + (int'(sel) + offset) % (DefaultRegCount - 1));
	endfunction

	task automatic idleFor(input int n);
		repeat (n) begin
			@(posedge CLK);
			exStrobe <= 1'b0;
			ldStrobe <= 1'b0;
		end
	endtask

	// lone strobe, then read the same register on both ports
	task automatic writeThenRead(input logic useLoad, input regIdxT sel, input wordT data);
		@(posedge CLK);
		if (useLoad) begin
			ldStrobe <= 1'b1;
			ldSel <= sel;
			ldData <= data;
		end else begin
			exStrobe <= 1'b1;
			exSel <= sel;
			exData <= data;
		end
		rsel1 <= sel;
		rsel2 <= sel;
		idleFor(3);
	endtask

	// both sources in one cycle, load goes second
	task automatic tieWrite(input regIdxT exReg, input wordT exVal,
		input regIdxT ldReg, input wordT ldVal);
		@(posedge CLK);
		exStrobe <= 1'b1;
		exSel <= exReg;
		exData <= exVal;
		ldStrobe <= 1'b1;
		ldSel <= ldReg;
		ldData <= ldVal;
		rsel1 <= exReg;
		rsel2 <= ldReg;
		idleFor(3);
	endtask

	// burst of legal traffic, then reads after the drain
	task automatic randomRound();
		logic exLast;
		logic ldLast;
		logic exNow;
		logic ldNow;
		exLast = 1'b0;
		ldLast = 1'b0;
		for (int i = 0; i < BurstLen; i++) begin
			exNow = !exLast && ($urandom % 2 == 0);
			ldNow = !ldLast && ($urandom % 2 == 0);
			@(posedge CLK);
			exStrobe <= exNow;
			exSel <= anyReg();
			exData <= randomWord();
			ldStrobe <= ldNow;
			ldSel <= anyReg();
			ldData <= randomWord();
			rsel1 <= anyReg();
			rsel2 <= anyReg();
			exLast = exNow;
			ldLast = ldNow;
		end
		idleFor(3);
		for (int i = 0; i < ReadLen; i++) begin
			@(posedge CLK);
			rsel1 <= anyReg();
			rsel2 <= anyReg();
		end
	endtask

	initial begin : mainFlow
		regIdxT a;
		regIdxT b;
		void'($urandom(Seed));
		rst <= 1'b1;
		exStrobe <= 1'b0;
		exSel <= ZeroReg;
		exData <= WordZeros;
		ldStrobe <= 1'b0;
		ldSel <= ZeroReg;
		ldData <= WordZeros;
		rsel1 <= ZeroReg;
		rsel2 <= ZeroReg;
		repeat (2) @(posedge CLK);
		rst <= 1'b0;
		idleFor(3);

		// all registers clear after reset
		for (int i = 0; i < DefaultRegCount; i++) begin
			@(posedge CLK);
			rsel1 <= regIdxT'(i);
			rsel2 <= regIdxT'(DefaultRegCount - 1 - i);
		end

		// writes to register 0 from each source and from a tie
		writeThenRead(1'b0, ZeroReg, WordOnes);
		writeThenRead(1'b1, ZeroReg, WordOnes);
		tieWrite(ZeroReg, randomWord(), ZeroReg, WordOnes);

		// write then read sweep, execute then load
		for (int r = 1; r < DefaultRegCount; r++) begin
			writeThenRead(1'b0, regIdxT'(r), randomWord());
		end
		for (int r = 1; r < DefaultRegCount; r++) begin
			writeThenRead(1'b1, regIdxT'(r), randomWord());
		end

		// ties to different and to the same register
		for (int i = 0; i < TieCount; i++) begin
			a = nonzeroReg();
			b = otherReg(a);
			tieWrite(a, randomWord(), b, randomWord());
			tieWrite(a, randomWord(), a, randomWord());
		end

		for (int i = 0; i < Rounds; i++) begin
			randomRound();
		end

		idleFor(4);
		$display("test passed");
		$finish;
	end

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("watchdog: the run did not finish within %0d cycles and is hung",
			WatchdogCycles);
		abortRun();
	end

endmodule

`default_nettype wire

// ==== sim.f ====
rfPkg.sv
writeArbiter.sv
regFile.sv
regFileTop.sv
regFileTb.sv

// ==== Makefile ====
# Verilator simulation of the register file testbench
VERILATOR = verilator
FLAGS = --binary --assert --timescale 1ns/100ps
TOP = regFileTb
FILELIST = sim.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "test passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
